// File: Makefile
# Verilator build and run of the divider testbench, run from the project root
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build div_tb with Verilator, run it, pass if the log has the pass line"
	@echo "make clean  remove obj_dir and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module div_tb -o div_tb
	./obj_dir/div_tb | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
verilog/div_pkg.sv
verilog/div_ctrl.sv
verilog/div_operand_prep.sv
verilog/div_goldschmidt.sv
verilog/div_fixup.sv
verilog/div_top.sv
dv/div_tb.sv

// File: dv/div_tb.sv
// testbench for div_top, directed vectors from dv/div_trace.txt then 200 random cases
// must run from the project root so the trace path resolves
// inputs change on the falling edge, outputs are sampled there too
// stops at the first mismatch, a watchdog bounds the whole run
`timescale 1ns/1ps
`default_nettype none

module div_tb import div_pkg::*; ();

    localparam int CLK_NS   = 100;
    localparam int N_RANDOM = 200;

    logic             clk = 1'b0;
    logic             rst_n;
    div_req_t         req;
    logic             start, ack;
    logic [OP_LN-1:0] result;
    logic             done;

    logic [2:0]       tr_f3[$];     // trace columns
    logic [OP_LN-1:0] tr_a[$], tr_b[$], tr_exp[$];
    int               n_ops   = 0;  // set once the trace is read
    int               op_idx  = 0;  // operation in flight
    logic             pending = 1'b0; // result shown, ack not yet given

    always #(CLK_NS/2) clk = ~clk;

    div_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .start  (start),
        .ack    (ack),
        .result (result),
        .done   (done)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "divider run stopped");
    endtask

    task automatic check_result(input logic [OP_LN-1:0] got, input logic [OP_LN-1:0] exp,
                                input div_fn_t fn);
        if (got !== exp) begin
            abort_run($sformatf("** Error: result (%s, op %0d) got 0x%08h expected 0x%08h",
                                fn.name(), op_idx, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: done (op %0d) got 0x%0h expected 0x%0h",
                                op_idx, got, exp));
        end
    endtask

    // RISC-V M-extension semantics, division truncates toward zero
    function automatic logic [OP_LN-1:0] ref_div(input div_fn_t fn, input logic [OP_LN-1:0] a,
                                                 input logic [OP_LN-1:0] b);
        logic signed [OP_LN-1:0] sa, sb;
        logic [OP_LN-1:0]        q, r;
        logic                    is_s;
        sa   = a;
        sb   = b;
        is_s = (fn == DIV) || (fn == REM);
        if (b == '0) begin
            q = '1;   // divide by zero
            r = a;
        end else if (is_s && (a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
            q = a;    // signed overflow
            r = '0;
        end else if (is_s) begin
            q = sa / sb;
            r = sa % sb;
        end else begin
            q = a / b;
            r = a % b;
        end
        return ((fn == DIV) || (fn == DIVU)) ? q : r;
    endfunction

    // edges past the accept edge until done is high
    // special cases register done on the accept edge itself, others NUM_ITER+1 edges later
    function automatic int done_edge(input div_fn_t fn, input logic [OP_LN-1:0] a,
                                     input logic [OP_LN-1:0] b);
        logic is_s;
        is_s = (fn == DIV) || (fn == REM);
        if ((b == '0) || (is_s && (a == 32'h8000_0000) && (b == 32'hffff_ffff))) begin
            return 0;
        end
        return NUM_ITER + 1;
    endfunction

    function automatic logic [OP_LN-1:0] pick_divisor();
        case ($urandom_range(7, 0))
            0: return '0;
            1: return '1;
            2: return $urandom_range(255, 1);               // small divisors
            3: return 32'h1 << $urandom_range(31, 0);        // powers of two
            4: return $urandom >> $urandom_range(31, 0);
            default: return $urandom;
        endcase
    endfunction

    // entered on a falling edge, returns on one with the result still pending or acked
    task automatic run_op(input logic [2:0] f3, input logic [OP_LN-1:0] a,
                          input logic [OP_LN-1:0] b, input logic [OP_LN-1:0] exp);
        div_fn_t fn;
        int      n_edge;
        int      hold;
        fn        = div_fn_t'(f3[1:0]);
        n_edge    = done_edge(fn, a, b);
        req.op1   = a;
        req.op2   = b;
        req.funct3 = f3;
        start     = 1'b1;
        ack       = pending;  // retire the previous result in the accept cycle
        @(negedge clk);       // accept edge has passed
        start   = 1'b0;
        ack     = 1'b0;
        pending = 1'b0;
        for (int c = 0; c <= n_edge; c++) begin
            if (c > 0) begin
                @(negedge clk);
            end
            check_done(done, c == n_edge); // c edges past accept, no early done
        end
        check_result(result, exp, fn);
        hold = $urandom_range(3, 0);     // back-pressure
        repeat (hold) begin
            @(negedge clk);
            check_done(done, 1'b1);
            check_result(result, exp, fn);
        end
        pending = 1'b1;
        if ($urandom_range(1, 0) == 0) begin
            ack = 1'b1;                  // ack alone, next start comes later
            @(negedge clk);
            ack     = 1'b0;
            pending = 1'b0;
            check_done(done, 1'b0);
            check_result(result, exp, fn); // result holds until the next finish
        end
    endtask

    initial begin : watchdog
        wait (n_ops > 0);
        #(CLK_NS * (12 * n_ops + 10));
        abort_run($sformatf("timeout: operation %0d of %0d never finished, controller in %s",
                            op_idx, n_ops, dut0.u_ctrl.state.name()));
    end

    initial begin
        int               fd;
        int               nread;
        string            line;
        logic [2:0]       f3;
        logic [OP_LN-1:0] a, b, e;
        div_fn_t          fn;
        rst_n = 1'b0;
        start = 1'b0;
        ack   = 1'b0;
        req   = '0;
        void'($urandom(2));   // one seed for the whole run

        fd = $fopen("dv/div_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open dv/div_trace.txt from the working directory");
        end
        while (!$feof(fd)) begin
            line  = "";
            nread = $fgets(line, fd);
            // comments fail the scan
            if ((nread > 0) && ($sscanf(line, "%h %h %h %h", f3, a, b, e) == 4)) begin
                tr_f3.push_back(f3);
                tr_a.push_back(a);
                tr_b.push_back(b);
                tr_exp.push_back(e);
            end
        end
        $fclose(fd);
        if (tr_f3.size() == 0) begin
            abort_run("trace file holds no vectors");
        end
        n_ops = tr_f3.size() + N_RANDOM;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_done(done, 1'b0);
        check_result(result, '0, DIV);

        foreach (tr_f3[i]) begin
            op_idx = i;
            run_op(tr_f3[i], tr_a[i], tr_b[i], tr_exp[i]);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            op_idx = tr_f3.size() + i;
            fn = div_fn_t'($urandom_range(3, 0));
            a  = ($urandom_range(15, 0) == 0) ? 32'h8000_0000 : $urandom;
            b  = pick_divisor();
            run_op({1'b1, fn}, a, b, ref_div(fn, a, b));
        end

        if (pending) begin
            ack = 1'b1;
            @(negedge clk);
            ack = 1'b0;
            check_done(done, 1'b0);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/div_trace.txt
# funct3 dividend divisor expected, all hex
# funct3 4 DIV, 5 DIVU, 6 REM, 7 REMU
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
5 ffffffff 00000001 ffffffff
5 ffffffff ffffffff 00000001
7 fffffffe ffffffff fffffffe
5 00000005 00000007 00000000
7 00000005 00000007 00000005
4 fffffffb 00000007 00000000
6 fffffffb 00000007 fffffffb
5 12345678 00000010 01234567
7 12345678 00000010 00000008
4 87654321 00000100 ff876544
6 87654321 00000100 ffffff21
5 80000000 80000000 00000001
5 ffffffff 00010000 0000ffff
7 ffffffff 00010000 0000ffff
4 00000064 00000000 ffffffff
6 00000064 00000000 00000064
5 ffffffff 00000000 ffffffff
7 80000001 00000000 80000001
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000
5 80000000 ffffffff 00000000
7 80000000 ffffffff 80000000
4 80000000 00000001 80000000
4 7fffffff 00000003 2aaaaaaa
6 7fffffff 00000003 00000001
5 00000000 00000003 00000000

// File: verilog/div_ctrl.sv
// sequencing FSM for the divider: IDLE -> ITERATE x NUM_ITER -> FIXUP -> IDLE
// special cases finish from IDLE in the accept cycle itself
// done is held until ack, start is accepted only in IDLE with no result pending
// unless ack retires the pending result in the same cycle
`timescale 1ns/1ps
`default_nettype none

module div_ctrl import div_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             start,
    input  wire             ack,
    input  wire div_kind_t  kind_now,
    output logic            load,
    output logic            step,
    output logic            finish,
    output logic            done
);

    div_state_t        state, state_nxt;
    logic [CNT_LN-1:0] cnt;      // completed steps
    logic              done_nxt;
    logic              accept;

    assign accept = start && (state == IDLE) && (!done || ack);

    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        step      = 1'b0;
        finish    = 1'b0;
        done_nxt  = done && !ack; // hold until ack
        case (state)
            IDLE: begin
                if (accept) begin
                    load = 1'b1;
                    if (kind_now != NORMAL) begin
                        finish   = 1'b1; // special result straight from the live request
                        done_nxt = 1'b1;
                    end else begin
                        state_nxt = ITERATE;
                    end
                end
            end
            ITERATE: begin
                step = 1'b1;
                if (cnt == CNT_LN'(NUM_ITER - 1)) begin
                    state_nxt = FIXUP;
                end
            end
            FIXUP: begin
                finish    = 1'b1;
                done_nxt  = 1'b1;
                state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            done  <= done_nxt;
            if (load) begin
                cnt <= '0;
            end else if (step) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // handshake rules seen from the requester side
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {ITERATE, FIXUP}) |-> !start)
        else $error("start while divider busy");

    a_no_start_held: assert property (@(posedge clk) disable iff (!rst_n)
        (done && !ack) |-> !start)
        else $error("start while result waits for ack");

    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == IDLE))
        else $error("done outside IDLE");

endmodule

`default_nettype wire

// File: verilog/div_fixup.sv
// exact result from the quotient estimate plus the RISC-V special values
// assumes quo_est is within one of the true quotient
// result loads only on finish and otherwise holds
`timescale 1ns/1ps
`default_nettype none

module div_fixup import div_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              finish,
    input  wire div_prep_t   prep,
    input  wire [OP_LN-1:0]  quo_est,
    output logic [OP_LN-1:0] result
);

    logic [OP_LN+1:0]        d_ext;
    logic [OP_LN+1:0]        prod_lo;  // d * q, true value fits in 34 bits
    logic signed [OP_LN+1:0] rem_raw;
    logic                    rem_neg, rem_big;
    logic [OP_LN-1:0]        quo_abs, rem_abs;
    logic [OP_LN+1:0]        rem_fix;
    logic [OP_LN-1:0]        quo_s, rem_s;
    logic [OP_LN-1:0]        quo_fin, rem_fin;
    logic                    is_quo;

    assign d_ext   = {2'b00, prep.op2_abs};
    assign prod_lo = prep.op2_abs * quo_est;
    assign rem_raw = $signed({2'b00, prep.op1_abs} - prod_lo);

    assign rem_neg = rem_raw[OP_LN+1];                          // estimate one too high
    assign rem_big = !rem_neg && ($unsigned(rem_raw) >= d_ext); // one too low

    always_comb begin
        quo_abs = quo_est;
        rem_fix = rem_raw;
        if (rem_neg) begin
            quo_abs = quo_est - 1'b1;
            rem_fix = rem_raw + d_ext;  // add back one divisor
        end else if (rem_big) begin
            quo_abs = quo_est + 1'b1;
            rem_fix = rem_raw - d_ext;
        end
    end

    assign rem_abs = rem_fix[OP_LN-1:0];
    assign quo_s   = prep.quo_neg ? -quo_abs : quo_abs;
    assign rem_s   = prep.op1_neg ? -rem_abs : rem_abs; // remainder follows the dividend

    always_comb begin
        case (prep.kind)
            DIV0: begin
                quo_fin = '1;
                rem_fin = prep.op1_raw;
            end
            OVFL: begin
                quo_fin = prep.op1_raw;
                rem_fin = '0;
            end
            default: begin
                quo_fin = quo_s;
                rem_fin = rem_s;
            end
        endcase
    end

    assign is_quo = (prep.fn == DIV) || (prep.fn == DIVU);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (finish) begin
            result <= is_quo ? quo_fin : rem_fin;
        end
    end

endmodule

`default_nettype wire

// File: verilog/div_goldschmidt.sv
// unsigned Goldschmidt quotient estimate, one multiply pass per step
// divisor is normalised to [0.5, 1), x = 1 - d, numerator scaled by (1 + x^(2^k))
// the estimate is rounded and may be one off in either direction,
// div_fixup settles the exact value from the remainder
`timescale 1ns/1ps
`default_nettype none

module div_goldschmidt import div_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              load,
    input  wire              step,
    input  wire div_prep_t   prep,
    output logic [OP_LN-1:0] quo_est
);

    logic [HB_LN-1:0]  norm_sh;           // left shift to bring msb to the top
    logic [OP_LN-1:0]  d_norm, x_frac;
    logic [C_LN-1:0]   x_init, num_init;
    logic [C_LN-1:0]   x_q, num_q;
    logic [C_LN-1:0]   x_next, num_next;
    logic [2*C_LN-1:0] x_sq;
    logic [C_LN:0]     mul_fac;           // 1.x with C_LN fraction bits
    logic [2*C_LN:0]   num_prod;
    logic              carry;             // product spilled past C_LN bits
    logic [HB_LN:0]    shft_init, shft_q; // final right shift, drops by one per carry
    logic [C_LN:0]     rnd_bit, num_rnd, num_shr;

    assign norm_sh  = HB_LN'(OP_LN - 1) - prep.op2_hb;
    assign d_norm   = prep.op2_abs << norm_sh;
    assign x_frac   = -d_norm;                          // 1 - d as a 0.32 fraction
    assign x_init   = {x_frac, {XP_LN{1'b0}}};
    assign num_init = {prep.op1_abs, {XP_LN{1'b0}}};

    // hb + 1 undoes the normalisation, XP_LN drops the guard bits
    assign shft_init = {1'b0, prep.op2_hb} + (HB_LN + 1)'(XP_LN + 1);

    // x squares every pass, keep the top C_LN bits
    assign x_sq   = x_q * x_q;
    assign x_next = x_sq[2*C_LN-1:C_LN];

    assign mul_fac  = {1'b1, x_q};
    assign num_prod = num_q * mul_fac;
    assign carry    = num_prod[2*C_LN];
    assign num_next = carry ? num_prod[2*C_LN:C_LN+1] // renormalise
                            : num_prod[2*C_LN-1:C_LN];

    always_ff @(posedge clk) begin
        if (load) begin
            x_q   <= x_init;
            num_q <= num_init;
        end else if (step) begin
            x_q   <= x_next;
            num_q <= num_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shft_q <= '0;
        end else if (load) begin
            shft_q <= shft_init;
        end else if (step && carry) begin
            shft_q <= shft_q - 1'b1;
        end
    end

    // round half up at the quotient lsb, shft_q never drops below XP_LN
    assign rnd_bit = (C_LN + 1)'(1) << (shft_q - 1'b1);
    assign num_rnd = {1'b0, num_q} + rnd_bit;
    assign num_shr = num_rnd >> shft_q;
    assign quo_est = (|num_shr[C_LN:OP_LN]) ? '1 : num_shr[OP_LN-1:0]; // saturate

    // steps only for NORMAL requests, and the highest-bit search must land the divisor msb on top
    a_step_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> ((prep.kind == NORMAL) && d_norm[OP_LN-1]))
        else $error("step without a normalised nonzero NORMAL divisor");

endmodule

`default_nettype wire

// File: verilog/div_operand_prep.sv
// decodes the request into magnitudes, signs and a special-case class
// prep is the live request during load and the captured one afterwards,
// so a one-cycle special case can be resolved in the accept cycle
// funct3[2] is ignored, only the M-extension divide group is expected here
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep import div_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            load,
    input  wire div_req_t  req,
    output div_kind_t      kind_now,
    output div_prep_t      prep
);

    div_fn_t          fn;
    logic             is_signed;
    logic             op1_neg, op2_neg;
    logic [OP_LN-1:0] op1_abs, op2_abs;
    logic [HB_LN-1:0] hb_chain [0:OP_LN]; // priority chain, lsb to msb
    div_prep_t        prep_now, prep_q;

    assign fn        = div_fn_t'(req.funct3[1:0]);
    assign is_signed = (fn == DIV) || (fn == REM);

    assign op1_neg = is_signed & req.op1[OP_LN-1];
    assign op2_neg = is_signed & req.op2[OP_LN-1];
    assign op1_abs = op1_neg ? -req.op1 : req.op1; // 0x80000000 stays as its own magnitude
    assign op2_abs = op2_neg ? -req.op2 : req.op2;

    // riscv special cases, checked on raw operands
    assign kind_now = (req.op2 == '0) ? DIV0 :
                      (is_signed && (req.op1 == {1'b1, {(OP_LN-1){1'b0}}}) && (req.op2 == '1))
                      ? OVFL : NORMAL;

    // highest set bit, later stages win, zero when no bit is set
    assign hb_chain[0] = '0;
    for (genvar i = 0; i < OP_LN; i++) begin : g_hb
        assign hb_chain[i+1] = op2_abs[i] ? HB_LN'(i) : hb_chain[i];
    end

    always_comb begin
        prep_now.fn      = fn;
        prep_now.kind    = kind_now;
        prep_now.op1_abs = op1_abs;
        prep_now.op2_abs = op2_abs;
        prep_now.op1_neg = op1_neg;
        prep_now.quo_neg = op1_neg ^ op2_neg;
        prep_now.op2_hb  = hb_chain[OP_LN];
        prep_now.op1_raw = req.op1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prep_q <= '0;
        end else if (load) begin
            prep_q <= prep_now;
        end
    end

    assign prep = load ? prep_now : prep_q; // bypass in the accept cycle

endmodule

`default_nettype wire

// File: verilog/div_pkg.sv
// shared widths, encodings and bundles for the 32-bit RISC-V M-extension divider
// div_fn_t values follow funct3[1:0] of DIV/DIVU/REM/REMU
// widths are fixed, nothing here is meant to be overridden per instance
`default_nettype none

package div_pkg;

    localparam int OP_LN    = 32;            // operand and result width
    localparam int XP_LN    = 4;             // extra fraction bits, must be >= 1
    localparam int C_LN     = OP_LN + XP_LN; // iteration datapath width
    localparam int NUM_ITER = 5;             // 5 passes cover 32 bits of precision
    localparam int CNT_LN   = 3;             // holds 0 .. NUM_ITER-1
    localparam int HB_LN    = 5;             // bit index into an operand

    // encoding matches funct3[1:0]
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_fn_t;

    typedef enum logic [1:0] {
        NORMAL = 2'b00, // full iteration path
        DIV0   = 2'b01, // divisor is zero
        OVFL   = 2'b10  // most negative / -1
    } div_kind_t;

    typedef enum logic [1:0] {IDLE, ITERATE, FIXUP} div_state_t;

    typedef struct packed {
        logic [OP_LN-1:0] op1;    // dividend
        logic [OP_LN-1:0] op2;    // divisor
        logic [2:0]       funct3;
    } div_req_t;

    typedef struct packed {
        div_fn_t          fn;
        div_kind_t        kind;
        logic [OP_LN-1:0] op1_abs;
        logic [OP_LN-1:0] op2_abs;
        logic             op1_neg; // sign of remainder
        logic             quo_neg; // sign of quotient
        logic [HB_LN-1:0] op2_hb;  // highest set bit of op2_abs
        logic [OP_LN-1:0] op1_raw; // untouched dividend for special results
    } div_prep_t;

endpackage

`default_nettype wire

// File: verilog/div_top.sv
// 32-bit integer divider, DIV/DIVU/REM/REMU selected by funct3[1:0]
// start is legal only while idle with no result waiting, or together with ack
// result and done hold until ack, one operation in flight at a time
// divide by zero and signed overflow finish 1 cycle after accept, others NUM_ITER+1
`timescale 1ns/1ps
`default_nettype none

module div_top import div_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire div_req_t    req,
    input  wire              start,
    input  wire              ack,
    output logic [OP_LN-1:0] result,
    output logic             done
);

    div_kind_t        kind_now; // classification of the live request
    logic             load;     // accept cycle
    logic             step;     // one iteration
    logic             finish;   // result register update
    div_prep_t        prep;
    logic [OP_LN-1:0] quo_est;  // unsigned estimate, within one of exact

    div_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .ack      (ack),
        .kind_now (kind_now),
        .load     (load),
        .step     (step),
        .finish   (finish),
        .done     (done)
    );

    div_operand_prep u_prep (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .req      (req),
        .kind_now (kind_now),
        .prep     (prep)
    );

    div_goldschmidt u_gold (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step    (step),
        .prep    (prep),
        .quo_est (quo_est)
    );

    div_fixup u_fixup (
        .clk     (clk),
        .rst_n   (rst_n),
        .finish  (finish),
        .prep    (prep),
        .quo_est (quo_est),
        .result  (result)
    );

endmodule

`default_nettype wire
